// File: include/owt_settings.svh
// owt receive hub settings

`ifndef OWT_SETTINGS_SVH
`define OWT_SETTINGS_SVH

// number of bus lines with one receiver each
`define OWT_CHAN_NUM  4

// clock cycles per manchester half-bit
`define OWT_HALF_CYC  4

// manchester zeros in the sync head
`define OWT_SYNC_BITS 4

// read address that carries 16-bit data
`define OWT_ADC_ADDR  7'h1f

`endif

// File: logic/owt_pkg.sv
// owt bus types

`default_nettype none

package owt_pkg;

    // bit 7 set for a write
    typedef logic [7:0]  owt_cmd_t;
    // 8-bit data in the low byte
    typedef logic [15:0] owt_data_t;
    typedef logic [7:0]  owt_crc_t;
    typedef logic [1:0]  owt_chan_t;

    typedef enum logic [2:0] {
        st_idle,
        st_sync_head,
        st_sync_tail,
        st_cmd,
        st_adc_data,
        st_nml_data,
        st_crc,
        st_end_tail
    } owt_rx_st_e;

endpackage

`default_nettype wire

// File: logic/owt_frame_if.sv
// owt finished frame

`timescale 1ns/100ps
`default_nettype none

interface owt_frame_if;

    // one-cycle pulse at the end of a frame
    logic               ack;
    // valid with ack
    logic               err;
    // held until the next frame starts
    owt_pkg::owt_cmd_t  cmd;
    owt_pkg::owt_data_t data;

    modport rx (
        output ack,
        output err,
        output cmd,
        output data
    );

    modport arb (
        input  ack,
        input  err,
        input  cmd,
        input  data
    );

endinterface

`default_nettype wire

// File: logic/owt_line_filter.sv
// owt line filter

`timescale 1ns/100ps
`default_nettype none
`include "owt_settings.svh"

module owt_line_filter (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic [`OWT_CHAN_NUM-1:0] i_line,
    output logic [`OWT_CHAN_NUM-1:0] o_sym_vld,
    output logic [`OWT_CHAN_NUM-1:0] o_sym_lvl
);

    localparam int CNT_W = $clog2(`OWT_HALF_CYC + 1);

    logic [`OWT_CHAN_NUM-1:0] sync_q1;
    logic [`OWT_CHAN_NUM-1:0] sync_q2;
    logic [`OWT_CHAN_NUM-1:0] lvl_q;

    // synchronizer with lines idle high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q1 <= '1;
            sync_q2 <= '1;
            lvl_q   <= '1;
        end else begin
            sync_q1 <= i_line;
            sync_q2 <= sync_q1;
            lvl_q   <= sync_q2;
        end
    end

    genvar g;
    generate
        for (g = 0; g < `OWT_CHAN_NUM; g++) begin : g_chan
            logic [CNT_W-1:0] hold_cnt;
            logic [CNT_W-1:0] cnt_nxt;
            logic             held;

            // restart on every level change
            assign cnt_nxt = (sync_q2[g] != lvl_q[g]) ? CNT_W'(1) : hold_cnt + 1'b1;
            assign held    = (cnt_nxt == CNT_W'(`OWT_HALF_CYC));

            always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                    hold_cnt     <= '0;
                    o_sym_vld[g] <= 1'b0;
                    o_sym_lvl[g] <= 1'b1;
                end else begin
                    hold_cnt     <= held ? '0 : cnt_nxt;
                    o_sym_vld[g] <= held;
                    o_sym_lvl[g] <= sync_q2[g];
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: logic/owt_crc8_serial.sv
// owt serial crc-8

`timescale 1ns/100ps
`default_nettype none

module owt_crc8_serial (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_vld,
    input  logic              i_bit,
    input  logic              i_start,
    output owt_pkg::owt_crc_t o_crc
);

    // x^8 + x^2 + x + 1
    localparam owt_pkg::owt_crc_t POLY = 8'h07;

    owt_pkg::owt_crc_t crc_base;
    logic              fb;

    // start bit is shifted into a cleared register
    assign crc_base = i_start ? '0 : o_crc;
    assign fb       = crc_base[7] ^ i_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_vld) begin
            o_crc <= {crc_base[6:0], 1'b0} ^ (fb ? POLY : '0);
        end
    end

endmodule

`default_nettype wire

// File: logic/owt_rx_frame.sv
// owt frame receiver

`timescale 1ns/100ps
`default_nettype none
`include "owt_settings.svh"

module owt_rx_frame (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_sym_vld,
    input  logic     i_sym_lvl,
    owt_frame_if.rx  frm
);

    owt_pkg::owt_rx_st_e st_q;
    owt_pkg::owt_rx_st_e st_nxt;

    logic               half_q;
    logic               first_lvl;
    logic               idle_hi;
    logic [4:0]         bit_cnt;
    logic [4:0]         last_idx;
    logic [2:0]         tail_q;
    logic [3:0]         tail_nxt;
    owt_pkg::owt_cmd_t  cmd_q;
    owt_pkg::owt_cmd_t  cmd_nxt;
    owt_pkg::owt_data_t data_q;
    owt_pkg::owt_crc_t  crc_rx_q;
    owt_pkg::owt_crc_t  crc_calc;
    logic               ack_q;
    logic               err_q;

    logic pair_done;
    logic pair_bad;
    logic paired_st;
    logic bit_stb;
    logic raw_stb;
    logic field_end;
    logic adc_rd;
    logic abort;
    logic frm_done;
    logic frm_bad;

    //==============================
    // symbol pairing
    //==============================
    // second half level is the bit value
    assign pair_done = i_sym_vld & half_q;
    assign pair_bad  = (first_lvl == i_sym_lvl);
    assign paired_st = st_q inside {owt_pkg::st_sync_head, owt_pkg::st_cmd,
                                    owt_pkg::st_adc_data, owt_pkg::st_nml_data,
                                    owt_pkg::st_crc};
    assign bit_stb   = pair_done & paired_st & ~pair_bad;
    assign raw_stb   = i_sym_vld & (st_q inside {owt_pkg::st_sync_tail, owt_pkg::st_end_tail});

    assign tail_nxt  = {tail_q, i_sym_lvl};
    assign cmd_nxt   = {cmd_q[6:0], i_sym_lvl};
    assign adc_rd    = ~cmd_nxt[7] & (cmd_nxt[6:0] == `OWT_ADC_ADDR);

    always_comb begin
        case (st_q)
            owt_pkg::st_sync_head: last_idx = 5'(`OWT_SYNC_BITS - 1);
            owt_pkg::st_adc_data:  last_idx = 5'd15;
            owt_pkg::st_cmd,
            owt_pkg::st_nml_data,
            owt_pkg::st_crc:       last_idx = 5'd7;
            default:               last_idx = 5'd3;
        endcase
    end

    assign field_end = (bit_cnt == last_idx);

    //==============================
    // frame fsm
    //==============================
    always_comb begin
        st_nxt   = st_q;
        abort    = 1'b0;
        frm_done = 1'b0;
        frm_bad  = 1'b0;
        case (st_q)
            owt_pkg::st_idle: begin
                // high then low strobe is the first sync zero
                if (i_sym_vld & ~i_sym_lvl & idle_hi) begin
                    st_nxt = owt_pkg::st_sync_head;
                end
            end
            owt_pkg::st_sync_head: begin
                if (pair_done) begin
                    if (pair_bad | i_sym_lvl) begin
                        abort = 1'b1;
                    end else if (field_end) begin
                        st_nxt = owt_pkg::st_sync_tail;
                    end
                end
            end
            owt_pkg::st_sync_tail: begin
                if (i_sym_vld & field_end) begin
                    if (tail_nxt == 4'b1100) begin
                        st_nxt = owt_pkg::st_cmd;
                    end else begin
                        abort = 1'b1;
                    end
                end
            end
            owt_pkg::st_cmd: begin
                if (pair_done) begin
                    if (pair_bad) begin
                        abort = 1'b1;
                    end else if (field_end) begin
                        st_nxt = adc_rd ? owt_pkg::st_adc_data : owt_pkg::st_nml_data;
                    end
                end
            end
            owt_pkg::st_adc_data,
            owt_pkg::st_nml_data: begin
                if (pair_done) begin
                    if (pair_bad) begin
                        abort = 1'b1;
                    end else if (field_end) begin
                        st_nxt = owt_pkg::st_crc;
                    end
                end
            end
            owt_pkg::st_crc: begin
                if (pair_done) begin
                    if (pair_bad) begin
                        abort = 1'b1;
                    end else if (field_end) begin
                        st_nxt = owt_pkg::st_end_tail;
                    end
                end
            end
            owt_pkg::st_end_tail: begin
                if (i_sym_vld & field_end) begin
                    st_nxt   = owt_pkg::st_idle;
                    frm_done = 1'b1;
                    frm_bad  = (tail_nxt != 4'b1100) | (crc_rx_q != crc_calc);
                end
            end
            default: st_nxt = owt_pkg::st_idle;
        endcase
        if (abort) begin
            st_nxt   = owt_pkg::st_idle;
            frm_done = 1'b1;
            frm_bad  = 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            st_q    <= owt_pkg::st_idle;
            half_q  <= 1'b0;
            idle_hi <= 1'b0;
            bit_cnt <= '0;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            st_q  <= st_nxt;
            ack_q <= frm_done;
            err_q <= frm_bad;
            if (st_q != st_nxt) begin
                half_q <= 1'b0;
            end else if (paired_st & i_sym_vld) begin
                half_q <= ~half_q;
            end
            // first sync zero is already counted when leaving idle
            if (st_q != st_nxt) begin
                bit_cnt <= (st_q == owt_pkg::st_idle) ? 5'd1 : 5'd0;
            end else if (bit_stb | raw_stb) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (st_q != owt_pkg::st_idle) begin
                idle_hi <= 1'b0;
            end else if (i_sym_vld) begin
                idle_hi <= i_sym_lvl;
            end
        end
    end

    //==============================
    // field shifters
    //==============================
    always_ff @(posedge i_clk) begin
        if (i_sym_vld & ~half_q) begin
            first_lvl <= i_sym_lvl;
        end
        if (raw_stb) begin
            tail_q <= tail_nxt[2:0];
        end
        if ((st_q == owt_pkg::st_idle) & (st_nxt == owt_pkg::st_sync_head)) begin
            cmd_q  <= '0;
            data_q <= '0;
        end else if (bit_stb & (st_q == owt_pkg::st_cmd)) begin
            cmd_q <= cmd_nxt;
        end else if (bit_stb & (st_q inside {owt_pkg::st_adc_data, owt_pkg::st_nml_data})) begin
            data_q <= {data_q[14:0], i_sym_lvl};
        end
        if (bit_stb & (st_q == owt_pkg::st_crc)) begin
            crc_rx_q <= {crc_rx_q[6:0], i_sym_lvl};
        end
    end

    // crc over cmd and data msb first
    owt_crc8_serial u_crc (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_vld   (bit_stb & (st_q inside {owt_pkg::st_cmd, owt_pkg::st_adc_data,
                                          owt_pkg::st_nml_data})),
        .i_bit   (i_sym_lvl),
        .i_start ((st_q == owt_pkg::st_cmd) & (bit_cnt == 5'd0)),
        .o_crc   (crc_calc)
    );

    assign frm.ack  = ack_q;
    assign frm.err  = err_q;
    assign frm.cmd  = cmd_q;
    assign frm.data = data_q;

endmodule

`default_nettype wire

// File: logic/owt_frame_arbiter.sv
// owt frame arbiter

`timescale 1ns/100ps
`default_nettype none
`include "owt_settings.svh"

module owt_frame_arbiter (
    input  logic               i_clk,
    input  logic               i_rst_n,
    owt_frame_if.arb           frm [`OWT_CHAN_NUM],
    output logic               o_frm_vld,
    output owt_pkg::owt_chan_t o_frm_chan,
    output owt_pkg::owt_cmd_t  o_frm_cmd,
    output owt_pkg::owt_data_t o_frm_data,
    output logic               o_frm_err
);

    logic [`OWT_CHAN_NUM-1:0] ack_vec;
    logic [`OWT_CHAN_NUM-1:0] pend_q;
    logic [`OWT_CHAN_NUM-1:0] err_hold;
    logic [`OWT_CHAN_NUM-1:0] cur_err;
    owt_pkg::owt_cmd_t        cmd_hold [`OWT_CHAN_NUM];
    owt_pkg::owt_cmd_t        cur_cmd  [`OWT_CHAN_NUM];
    owt_pkg::owt_data_t       data_hold[`OWT_CHAN_NUM];
    owt_pkg::owt_data_t       cur_data [`OWT_CHAN_NUM];
    owt_pkg::owt_chan_t       last_q;
    owt_pkg::owt_chan_t       grant_idx;
    logic                     grant_vld;

    genvar g;
    generate
        for (g = 0; g < `OWT_CHAN_NUM; g++) begin : g_slot
            assign ack_vec[g] = frm[g].ack;

            always_ff @(posedge i_clk) begin
                if (frm[g].ack) begin
                    err_hold[g]  <= frm[g].err;
                    cmd_hold[g]  <= frm[g].cmd;
                    data_hold[g] <= frm[g].data;
                end
            end

            // a frame acked this cycle can go out at once
            assign cur_err[g]  = frm[g].ack ? frm[g].err  : err_hold[g];
            assign cur_cmd[g]  = frm[g].ack ? frm[g].cmd  : cmd_hold[g];
            assign cur_data[g] = frm[g].ack ? frm[g].data : data_hold[g];
        end
    endgenerate

    // round robin search starting after the last grant
    always_comb begin
        int idx;
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= `OWT_CHAN_NUM; k++) begin
            idx = (int'(last_q) + k) % `OWT_CHAN_NUM;
            if (!grant_vld && (pend_q[idx] || ack_vec[idx])) begin
                grant_vld = 1'b1;
                grant_idx = owt_pkg::owt_chan_t'(idx);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend_q    <= '0;
            last_q    <= '0;
            o_frm_vld <= 1'b0;
        end else begin
            o_frm_vld <= grant_vld;
            for (int ch = 0; ch < `OWT_CHAN_NUM; ch++) begin
                if (grant_vld && (int'(grant_idx) == ch)) begin
                    pend_q[ch] <= 1'b0;
                end else if (ack_vec[ch]) begin
                    pend_q[ch] <= 1'b1;
                end
            end
            if (grant_vld) begin
                last_q <= grant_idx;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (grant_vld) begin
            o_frm_chan <= grant_idx;
            o_frm_cmd  <= cur_cmd[grant_idx];
            o_frm_data <= cur_data[grant_idx];
            o_frm_err  <= cur_err[grant_idx];
        end
    end

endmodule

`default_nettype wire

// File: logic/owt_rx_hub.sv
// owt receive hub

`timescale 1ns/100ps
`default_nettype none
`include "owt_settings.svh"

module owt_rx_hub (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic [`OWT_CHAN_NUM-1:0] i_owt_line,
    output logic                     o_frm_vld,
    output owt_pkg::owt_chan_t       o_frm_chan,
    output owt_pkg::owt_cmd_t        o_frm_cmd,
    output owt_pkg::owt_data_t       o_frm_data,
    output logic                     o_frm_err
);

    logic [`OWT_CHAN_NUM-1:0] sym_vld;
    logic [`OWT_CHAN_NUM-1:0] sym_lvl;

    owt_frame_if frm_if [`OWT_CHAN_NUM] ();

    owt_line_filter u_filter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_line    (i_owt_line),
        .o_sym_vld (sym_vld),
        .o_sym_lvl (sym_lvl)
    );

    // one receiver per line
    genvar g;
    generate
        for (g = 0; g < `OWT_CHAN_NUM; g++) begin : g_rx
            owt_rx_frame u_rx (
                .i_clk     (i_clk),
                .i_rst_n   (i_rst_n),
                .i_sym_vld (sym_vld[g]),
                .i_sym_lvl (sym_lvl[g]),
                .frm       (frm_if[g])
            );
        end
    endgenerate

    owt_frame_arbiter u_arb (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .frm        (frm_if),
        .o_frm_vld  (o_frm_vld),
        .o_frm_chan (o_frm_chan),
        .o_frm_cmd  (o_frm_cmd),
        .o_frm_data (o_frm_data),
        .o_frm_err  (o_frm_err)
    );

endmodule

`default_nettype wire

// File: sim/tb_owt_rx_hub.sv
// owt receive hub testbench

`timescale 1ns/100ps
`default_nettype none
`include "owt_settings.svh"

module tb_owt_rx_hub;

    localparam int          RST_CYC     = 3;
    localparam int          QUIET_CYC   = 40;
    localparam int          START_CYC   = RST_CYC + QUIET_CYC + 4;
    localparam int          FRAMES      = 11;
    localparam int          GAP_MIN     = 8;
    localparam int          TIMEOUT_CYC = 20000;
    localparam logic [31:0] SEED        = 32'h739d;

    // frame kinds where a cut frame is always followed by a plain one
    localparam int K_PLAIN = 0;
    localparam int K_ADC   = 1;
    localparam int K_CRC   = 2;
    localparam int K_TAIL  = 3;
    localparam int K_CUT   = 4;

    typedef struct packed {
        owt_pkg::owt_cmd_t  cmd;
        owt_pkg::owt_data_t data;
        logic               err;
        logic               err_only;
    } frame_t;

    logic                     clk;
    logic                     rst_n;
    wire  [`OWT_CHAN_NUM-1:0] line;
    wire  [`OWT_CHAN_NUM-1:0] chan_done;
    logic                     quiet_chk;

    logic                     frm_vld;
    owt_pkg::owt_chan_t       frm_chan;
    owt_pkg::owt_cmd_t        frm_cmd;
    owt_pkg::owt_data_t       frm_data;
    logic                     frm_err;

    frame_t exp_q [`OWT_CHAN_NUM][$];
    int     mismatch_cnt;
    int     extra_cnt;
    int     end_cnt;

    owt_rx_hub u_dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_owt_line (line),
        .o_frm_vld  (frm_vld),
        .o_frm_chan (frm_chan),
        .o_frm_cmd  (frm_cmd),
        .o_frm_data (frm_data),
        .o_frm_err  (frm_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //==============================
    // reference model
    //==============================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // crc-8 with poly 0x07 over cmd then data msb first
    function automatic owt_pkg::owt_crc_t crc8_model(input owt_pkg::owt_cmd_t cmd,
                                                     input owt_pkg::owt_data_t data,
                                                     input logic wide);
        logic [23:0]       bits;
        int                n;
        owt_pkg::owt_crc_t crc;
        logic              fb;
        bits = wide ? {cmd, data} : {cmd, data[7:0], 8'h00};
        n    = wide ? 24 : 16;
        crc  = '0;
        for (int i = 23; i >= 24 - n; i--) begin
            fb  = crc[7] ^ bits[i];
            crc = {crc[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return crc;
    endfunction

    function automatic logic queues_empty();
        for (int c = 0; c < `OWT_CHAN_NUM; c++) begin
            if (exp_q[c].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    //==============================
    // line drivers per channel
    //==============================
    genvar g;
    generate
        for (g = 0; g < `OWT_CHAN_NUM; g++) begin : g_drv
            logic        lvl;
            logic        done;
            logic [31:0] rng;

            assign line[g]      = lvl;
            assign chan_done[g] = done;

            function automatic logic [31:0] rand_word();
                rng = xorshift(rng);
                return rng;
            endfunction

            task automatic drive_half(input logic v);
                lvl = v;
                repeat (`OWT_HALF_CYC) @(negedge clk);
            endtask

            // one is low then high and zero is high then low
            task automatic send_bit(input logic b);
                drive_half(~b);
                drive_half(b);
            endtask

            task automatic shift_out(input logic [15:0] v, input int n);
                for (int i = n - 1; i >= 0; i--) begin
                    send_bit(v[i]);
                end
            endtask

            task automatic transmit_frame(input owt_pkg::owt_cmd_t cmd,
                                          input owt_pkg::owt_data_t data,
                                          input logic wide,
                                          input owt_pkg::owt_crc_t crc,
                                          input logic [3:0] tail,
                                          input int cut_at);
                for (int i = 0; i < `OWT_SYNC_BITS; i++) begin
                    send_bit(1'b0);
                end
                for (int i = 3; i >= 0; i--) begin
                    drive_half(i >= 2);
                end
                if (cut_at >= 0) begin
                    // leading cmd bits then low low
                    shift_out(16'(cmd >> (8 - cut_at)), cut_at);
                    drive_half(1'b0);
                    drive_half(1'b0);
                end else begin
                    shift_out(16'(cmd), 8);
                    shift_out(data, wide ? 16 : 8);
                    shift_out(16'(crc), 8);
                    for (int i = 3; i >= 0; i--) begin
                        drive_half(tail[i]);
                    end
                end
                lvl = 1'b1;
            endtask

            initial begin
                frame_t             want;
                owt_pkg::owt_cmd_t  cmd;
                owt_pkg::owt_data_t data;
                owt_pkg::owt_crc_t  crc;
                logic               wide;
                logic [3:0]         tail;
                logic [31:0]        r;
                int                 kind;
                int                 cut_at;
                lvl  = 1'b1;
                done = 1'b0;
                rng  = SEED ^ (32'(g) << 16);
                r    = rand_word();
                repeat (START_CYC + int'(r[5:0])) @(negedge clk);
                for (int k = 0; k < FRAMES; k++) begin
                    kind   = (k + g) % 5;
                    r      = rand_word();
                    cmd    = r[7:0];
                    data   = {8'h00, r[15:8]};
                    wide   = 1'b0;
                    tail   = 4'b1100;
                    cut_at = -1;
                    if (kind == K_ADC) begin
                        cmd  = {1'b0, `OWT_ADC_ADDR};
                        data = r[31:16];
                        wide = 1'b1;
                    end else if (!cmd[7] && (cmd[6:0] == `OWT_ADC_ADDR)) begin
                        cmd[7] = 1'b1;
                    end
                    crc           = crc8_model(cmd, data, wide);
                    want.cmd      = cmd;
                    want.data     = data;
                    want.err      = 1'b0;
                    want.err_only = 1'b0;
                    r = rand_word();
                    case (kind)
                        K_CRC: begin
                            crc      = crc ^ (8'h01 << r[2:0]);
                            want.err = 1'b1;
                        end
                        K_TAIL: begin
                            tail     = (r[3:0] == 4'b1100) ? 4'b0110 : r[3:0];
                            want.err = 1'b1;
                        end
                        K_CUT: begin
                            cut_at        = int'(r[2:0]);
                            want.err      = 1'b1;
                            want.err_only = 1'b1;
                        end
                        K_PLAIN,
                        K_ADC: ;
                        default: ;
                    endcase
                    exp_q[g].push_back(want);
                    transmit_frame(cmd, data, wide, crc, tail, cut_at);
                    repeat (GAP_MIN + int'(r[12:8])) @(negedge clk);
                end
                done = 1'b1;
            end
        end
    endgenerate

    //==============================
    // monitor
    //==============================
    task automatic compare_field(input string name, input logic [15:0] got,
                                 input logic [15:0] exp, input int ch);
        assert (got === exp) else begin
            $display("mismatch %s on channel %0d: got %h expected %h", name, ch, got, exp);
            mismatch_cnt++;
        end
    endtask

    always @(negedge clk) begin
        frame_t want;
        int     ch;
        if (quiet_chk) begin
            assert (frm_vld === 1'b0) else begin
                $display("mismatch o_frm_vld: got %h expected %h", frm_vld, 1'b0);
                mismatch_cnt++;
            end
        end
        if (frm_vld === 1'b1) begin
            ch = int'(frm_chan);
            assert (exp_q[ch].size() > 0) else begin
                $display("frame came out on channel %0d with none expected there", ch);
                extra_cnt++;
            end
            if (exp_q[ch].size() > 0) begin
                want = exp_q[ch].pop_front();
                if (!want.err_only) begin
                    compare_field("o_frm_cmd", 16'(frm_cmd), 16'(want.cmd), ch);
                    compare_field("o_frm_data", frm_data, want.data, ch);
                end
                compare_field("o_frm_err", 16'(frm_err), 16'(want.err), ch);
            end
        end
    end

    //==============================
    // main sequence
    //==============================
    initial begin
        int cyc;
        rst_n        = 1'b0;
        quiet_chk    = 1'b0;
        mismatch_cnt = 0;
        extra_cnt    = 0;
        end_cnt      = 0;
        repeat (RST_CYC) @(negedge clk);
        rst_n = 1'b1;
        // no frame may come out while the lines idle high
        @(posedge clk);
        quiet_chk = 1'b1;
        repeat (QUIET_CYC) @(posedge clk);
        quiet_chk = 1'b0;
        cyc = 0;
        while (!((chan_done == '1) && queues_empty()) && (cyc < TIMEOUT_CYC)) begin
            @(posedge clk);
            cyc++;
        end
        assert (cyc < TIMEOUT_CYC) else begin
            $display("timeout while waiting for all sent frames to come out");
            end_cnt++;
        end
        // catch late or duplicate frames
        repeat (40) @(posedge clk);
        $display("errors: %0d mismatch, %0d unexpected frame, %0d end of run",
                 mismatch_cnt, extra_cnt, end_cnt);
        if ((mismatch_cnt == 0) && (extra_cnt == 0) && (end_cnt == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
logic/owt_pkg.sv
logic/owt_frame_if.sv
logic/owt_line_filter.sv
logic/owt_crc8_serial.sv
logic/owt_rx_frame.sv
logic/owt_frame_arbiter.sv
logic/owt_rx_hub.sv
sim/tb_owt_rx_hub.sv

// File: Bender.yml
package:
  name: owt_rx_hub

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/owt_pkg.sv
      - logic/owt_frame_if.sv
      - logic/owt_line_filter.sv
      - logic/owt_crc8_serial.sv
      - logic/owt_rx_frame.sv
      - logic/owt_frame_arbiter.sv
      - logic/owt_rx_hub.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_owt_rx_hub.sv
